/* flist.f */
logic/ctrl_pkg.sv
logic/fetch_port.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/pipe_controller.sv
test/pipe_controller_props.sv
test/pipe_controller_tb.sv

/* logic/ctrl_pkg.sv */
package ctrl_pkg;

    // instruction and address words
    typedef logic [31:0] word_t;

    // register file index
    typedef logic [3:0] reg_idx_t;

    // data processing immediate field
    typedef logic [11:0] imm12_t;

    // nzcv with n in the msb
    typedef logic [3:0] flags_t;

    // instruction class in bits 27..26
    typedef enum logic [1:0] {
        cls_dp     = 2'b00,
        cls_mem    = 2'b01,
        cls_branch = 2'b10,
        cls_undef  = 2'b11
    } instr_class_e;

    // condition field, code 15 is never
    typedef enum logic [3:0] {
        cond_eq = 4'd0,
        cond_ne = 4'd1,
        cond_cs = 4'd2,
        cond_cc = 4'd3,
        cond_mi = 4'd4,
        cond_pl = 4'd5,
        cond_vs = 4'd6,
        cond_vc = 4'd7,
        cond_hi = 4'd8,
        cond_ls = 4'd9,
        cond_ge = 4'd10,
        cond_lt = 4'd11,
        cond_gt = 4'd12,
        cond_le = 4'd13,
        cond_al = 4'd14
    } cond_e;

    // data processing opcodes in bits 24..21
    typedef enum logic [3:0] {
        op_and = 4'd0,
        op_eor = 4'd1,
        op_sub = 4'd2,
        op_rsb = 4'd3,
        op_add = 4'd4,
        op_adc = 4'd5,
        op_sbc = 4'd6,
        op_rsc = 4'd7,
        op_tst = 4'd8,
        op_teq = 4'd9,
        op_cmp = 4'd10,
        op_cmn = 4'd11,
        op_orr = 4'd12,
        op_mov = 4'd13,
        op_bic = 4'd14,
        op_mvn = 4'd15
    } alu_op_e;

    // link register written by branch with link
    localparam reg_idx_t lr_idx = 4'd14;

endpackage

/* logic/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,

    // from fetch
    input  logic                   f_valid,
    input  ctrl_pkg::word_t        f_instr,
    input  ctrl_pkg::word_t        f_pc,

    // squash from execute
    input  logic                   redirect,

    // decoded instruction
    output logic                   d_valid,
    output ctrl_pkg::word_t        d_pc,
    output ctrl_pkg::cond_e        d_cond,
    output ctrl_pkg::instr_class_e d_class,
    output logic                   d_imm_flag,
    output logic                   d_set_flags,
    output logic                   d_link,
    output logic                   d_load,
    output ctrl_pkg::alu_op_e      d_alu_op,
    output ctrl_pkg::reg_idx_t     d_rn,
    output ctrl_pkg::reg_idx_t     d_rd,
    output ctrl_pkg::reg_idx_t     d_rm,
    output ctrl_pkg::imm12_t       d_imm12,
    output ctrl_pkg::word_t        d_offset
);

    ctrl_pkg::word_t d_instr;

    // younger word arriving with a redirect is dropped too
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= f_valid && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (f_valid) begin
            d_instr <= f_instr;
            d_pc    <= f_pc;
        end
    end

    // field extraction
    assign d_cond      = ctrl_pkg::cond_e'(d_instr[31:28]);
    assign d_class     = ctrl_pkg::instr_class_e'(d_instr[27:26]);
    assign d_imm_flag  = d_instr[25];
    assign d_alu_op    = ctrl_pkg::alu_op_e'(d_instr[24:21]);
    assign d_set_flags = d_instr[20];
    assign d_rn        = d_instr[19:16];
    assign d_rd        = d_instr[15:12];
    assign d_rm        = d_instr[3:0];
    assign d_imm12     = d_instr[11:0];

    // L bit shares bit 20 with the S bit
    assign d_load = d_instr[20];
    assign d_link = d_instr[24];

    // word offset, sign extended and scaled to bytes
    assign d_offset = {{6{d_instr[23]}}, d_instr[23:0], 2'b00};

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  ctrl_pkg::flags_t       flags,

    // from decode
    input  logic                   d_valid,
    input  ctrl_pkg::word_t        d_pc,
    input  ctrl_pkg::cond_e        d_cond,
    input  ctrl_pkg::instr_class_e d_class,
    input  logic                   d_imm_flag,
    input  logic                   d_set_flags,
    input  logic                   d_link,
    input  logic                   d_load,
    input  ctrl_pkg::alu_op_e      d_alu_op,
    input  ctrl_pkg::reg_idx_t     d_rn,
    input  ctrl_pkg::reg_idx_t     d_rd,
    input  ctrl_pkg::reg_idx_t     d_rm,
    input  ctrl_pkg::imm12_t       d_imm12,
    input  ctrl_pkg::word_t        d_offset,

    // branch back to fetch and decode
    output logic                   redirect,
    output ctrl_pkg::word_t        redirect_pc,

    // execute control word
    output logic                   ex_valid,
    output logic                   ex_pass,
    output ctrl_pkg::alu_op_e      alu_op,
    output ctrl_pkg::reg_idx_t     rn,
    output ctrl_pkg::reg_idx_t     rm,
    output ctrl_pkg::imm12_t       imm12,
    output logic                   use_imm,
    output logic                   en_status,
    output logic                   mem_r_en,
    output logic                   mem_w_en,

    // toward result stage
    output ctrl_pkg::instr_class_e x_class,
    output logic                   x_load,
    output logic                   x_link,
    output ctrl_pkg::reg_idx_t     x_rd,
    output logic                   x_writes_rd
);

    logic take;
    logic pass;
    logic is_compare;

    function automatic logic cond_ok(input ctrl_pkg::cond_e cond, input ctrl_pkg::flags_t f);
        logic n;
        logic z;
        logic c;
        logic v;
        n = f[3];
        z = f[2];
        c = f[1];
        v = f[0];
        case (cond)
            ctrl_pkg::cond_eq: cond_ok = z;
            ctrl_pkg::cond_ne: cond_ok = !z;
            ctrl_pkg::cond_cs: cond_ok = c;
            ctrl_pkg::cond_cc: cond_ok = !c;
            ctrl_pkg::cond_mi: cond_ok = n;
            ctrl_pkg::cond_pl: cond_ok = !n;
            ctrl_pkg::cond_vs: cond_ok = v;
            ctrl_pkg::cond_vc: cond_ok = !v;
            ctrl_pkg::cond_hi: cond_ok = c && !z;
            ctrl_pkg::cond_ls: cond_ok = !c || z;
            ctrl_pkg::cond_ge: cond_ok = (n == v);
            ctrl_pkg::cond_lt: cond_ok = (n != v);
            ctrl_pkg::cond_gt: cond_ok = !z && (n == v);
            ctrl_pkg::cond_le: cond_ok = z || (n != v);
            ctrl_pkg::cond_al: cond_ok = 1'b1;
            // code 15, never
            default:           cond_ok = 1'b0;
        endcase
    endfunction

    // the input seen while redirect is high is younger than the branch
    assign take = d_valid && !redirect;
    assign pass = take && cond_ok(d_cond, flags);

    assign is_compare = (d_alu_op == ctrl_pkg::op_tst) || (d_alu_op == ctrl_pkg::op_teq) ||
                        (d_alu_op == ctrl_pkg::op_cmp) || (d_alu_op == ctrl_pkg::op_cmn);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            ex_pass   <= 1'b0;
            en_status <= 1'b0;
            mem_r_en  <= 1'b0;
            mem_w_en  <= 1'b0;
            redirect  <= 1'b0;
        end else begin
            ex_valid  <= take;
            ex_pass   <= pass;
            en_status <= pass && (d_class == ctrl_pkg::cls_dp) && d_set_flags;
            mem_r_en  <= pass && (d_class == ctrl_pkg::cls_mem) && d_load;
            mem_w_en  <= pass && (d_class == ctrl_pkg::cls_mem) && !d_load;
            redirect  <= pass && (d_class == ctrl_pkg::cls_branch);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            alu_op      <= d_alu_op;
            rn          <= d_rn;
            rm          <= d_rm;
            imm12       <= d_imm12;
            use_imm     <= d_imm_flag;
            x_class     <= d_class;
            x_load      <= d_load;
            x_link      <= d_link;
            x_rd        <= d_rd;
            x_writes_rd <= (d_class == ctrl_pkg::cls_dp) && !is_compare;
            // pc reads two words ahead
            redirect_pc <= d_pc + 32'd8 + d_offset;
        end
    end

endmodule

/* logic/fetch_port.sv */
`timescale 1ns/10ps

module fetch_port #(
    parameter ctrl_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst_n,

    // instruction memory, four-phase req/ack
    input  logic            imem_ack,
    input  ctrl_pkg::word_t imem_rdata,
    output logic            imem_req,
    output ctrl_pkg::word_t imem_addr,

    // taken branch from execute
    input  logic            redirect,
    input  ctrl_pkg::word_t redirect_pc,

    // fetched word toward decode
    output logic            f_valid,
    output ctrl_pkg::word_t f_instr,
    output ctrl_pkg::word_t f_pc
);

    typedef enum logic [1:0] {
        st_boot,
        st_request,
        st_release,
        st_deliver
    } fetch_state_e;

    fetch_state_e    state;
    ctrl_pkg::word_t pc;
    ctrl_pkg::word_t pend_pc;
    logic            drop;

    // pc stays put from request until deliver, so the address is stable
    assign imem_req  = (state == st_request);
    assign imem_addr = pc;
    assign f_pc      = pc;
    assign f_valid   = (state == st_deliver) && !drop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_boot;
            pc    <= '0;
            drop  <= 1'b0;
        end else begin
            case (state)
                st_boot: begin
                    pc    <= RESET_VECTOR;
                    state <= st_request;
                end
                st_request: begin
                    if (imem_ack) begin
                        state <= st_release;
                    end
                end
                st_release: begin
                    // wait for the memory to drop ack
                    if (!imem_ack) begin
                        state <= st_deliver;
                    end
                end
                st_deliver: begin
                    // latest redirect wins over a remembered one
                    if (redirect) begin
                        pc <= redirect_pc;
                    end else if (drop) begin
                        pc <= pend_pc;
                    end else begin
                        pc <= pc + 32'd4;
                    end
                    drop  <= 1'b0;
                    state <= st_request;
                end
                default: begin
                    state <= st_boot;
                end
            endcase

            // redirect during a fetch in flight kills that word
            if (redirect && (state == st_request || state == st_release)) begin
                drop <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_request && imem_ack) begin
            f_instr <= imem_rdata;
        end
        if (redirect) begin
            pend_pc <= redirect_pc;
        end
    end

endmodule

/* logic/pipe_controller.sv */
`timescale 1ns/10ps

module pipe_controller #(
    parameter ctrl_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst_n,

    // instruction memory
    output logic               imem_req,
    output ctrl_pkg::word_t    imem_addr,
    input  logic               imem_ack,
    input  ctrl_pkg::word_t    imem_rdata,

    // status flags from the datapath
    input  ctrl_pkg::flags_t   flags,

    // execute outputs
    output logic               ex_valid,
    output logic               ex_pass,
    output ctrl_pkg::alu_op_e  alu_op,
    output ctrl_pkg::reg_idx_t rn,
    output ctrl_pkg::reg_idx_t rm,
    output ctrl_pkg::imm12_t   imm12,
    output logic               use_imm,
    output logic               en_status,
    output logic               mem_r_en,
    output logic               mem_w_en,
    output logic               redirect,
    output ctrl_pkg::word_t    redirect_pc,

    // write-back outputs
    output logic               wb_valid,
    output logic               reg_w_en,
    output logic               ldr_w_en,
    output ctrl_pkg::reg_idx_t reg_w_addr
);

    logic                   f_valid;
    ctrl_pkg::word_t        f_instr;
    ctrl_pkg::word_t        f_pc;

    logic                   d_valid;
    ctrl_pkg::word_t        d_pc;
    ctrl_pkg::cond_e        d_cond;
    ctrl_pkg::instr_class_e d_class;
    logic                   d_imm_flag;
    logic                   d_set_flags;
    logic                   d_link;
    logic                   d_load;
    ctrl_pkg::alu_op_e      d_alu_op;
    ctrl_pkg::reg_idx_t     d_rn;
    ctrl_pkg::reg_idx_t     d_rd;
    ctrl_pkg::reg_idx_t     d_rm;
    ctrl_pkg::imm12_t       d_imm12;
    ctrl_pkg::word_t        d_offset;

    ctrl_pkg::instr_class_e x_class;
    logic                   x_load;
    logic                   x_link;
    ctrl_pkg::reg_idx_t     x_rd;
    logic                   x_writes_rd;

    fetch_port #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_ack    (imem_ack),
        .imem_rdata  (imem_rdata),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .f_valid     (f_valid),
        .f_instr     (f_instr),
        .f_pc        (f_pc)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .f_valid     (f_valid),
        .f_instr     (f_instr),
        .f_pc        (f_pc),
        .redirect    (redirect),
        .d_valid     (d_valid),
        .d_pc        (d_pc),
        .d_cond      (d_cond),
        .d_class     (d_class),
        .d_imm_flag  (d_imm_flag),
        .d_set_flags (d_set_flags),
        .d_link      (d_link),
        .d_load      (d_load),
        .d_alu_op    (d_alu_op),
        .d_rn        (d_rn),
        .d_rd        (d_rd),
        .d_rm        (d_rm),
        .d_imm12     (d_imm12),
        .d_offset    (d_offset)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .flags       (flags),
        .d_valid     (d_valid),
        .d_pc        (d_pc),
        .d_cond      (d_cond),
        .d_class     (d_class),
        .d_imm_flag  (d_imm_flag),
        .d_set_flags (d_set_flags),
        .d_link      (d_link),
        .d_load      (d_load),
        .d_alu_op    (d_alu_op),
        .d_rn        (d_rn),
        .d_rd        (d_rd),
        .d_rm        (d_rm),
        .d_imm12     (d_imm12),
        .d_offset    (d_offset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_valid    (ex_valid),
        .ex_pass     (ex_pass),
        .alu_op      (alu_op),
        .rn          (rn),
        .rm          (rm),
        .imm12       (imm12),
        .use_imm     (use_imm),
        .en_status   (en_status),
        .mem_r_en    (mem_r_en),
        .mem_w_en    (mem_w_en),
        .x_class     (x_class),
        .x_load      (x_load),
        .x_link      (x_link),
        .x_rd        (x_rd),
        .x_writes_rd (x_writes_rd)
    );

    result_stage u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .x_valid     (ex_valid),
        .x_pass      (ex_pass),
        .x_class     (x_class),
        .x_load      (x_load),
        .x_link      (x_link),
        .x_rd        (x_rd),
        .x_writes_rd (x_writes_rd),
        .wb_valid    (wb_valid),
        .reg_w_en    (reg_w_en),
        .ldr_w_en    (ldr_w_en),
        .reg_w_addr  (reg_w_addr)
    );

endmodule

/* logic/result_stage.sv */
`timescale 1ns/10ps

module result_stage (
    input  logic                   clk,
    input  logic                   rst_n,

    // from execute
    input  logic                   x_valid,
    input  logic                   x_pass,
    input  ctrl_pkg::instr_class_e x_class,
    input  logic                   x_load,
    input  logic                   x_link,
    input  ctrl_pkg::reg_idx_t     x_rd,
    input  logic                   x_writes_rd,

    // write-back enables
    output logic                   wb_valid,
    output logic                   reg_w_en,
    output logic                   ldr_w_en,
    output ctrl_pkg::reg_idx_t     reg_w_addr
);

    logic dp_write;
    logic bl_write;
    logic ld_write;

    assign dp_write = x_valid && x_pass && (x_class == ctrl_pkg::cls_dp) && x_writes_rd;
    assign bl_write = x_valid && x_pass && (x_class == ctrl_pkg::cls_branch) && x_link;
    assign ld_write = x_valid && x_pass && (x_class == ctrl_pkg::cls_mem) && x_load;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            reg_w_en <= 1'b0;
            ldr_w_en <= 1'b0;
        end else begin
            wb_valid <= x_valid;
            reg_w_en <= dp_write || bl_write;
            ldr_w_en <= ld_write;
        end
    end

    // branch with link saves the return address in lr
    always_ff @(posedge clk) begin
        if (x_valid) begin
            reg_w_addr <= bl_write ? ctrl_pkg::lr_idx : x_rd;
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the pipeline controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module pipe_controller_tb \
    -f flist.f \
    -o sim_pipe_controller

# the log decides the result, so a fatal exit must not stop the script here
./obj_dir/sim_pipe_controller | tee sim.log || true

if grep -q "RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* test/pipe_controller_props.sv */
`timescale 1ns/10ps

module pipe_controller_props (
    input logic        clk,
    input logic        rst_n,
    input logic        imem_req,
    input logic        imem_ack,
    input logic [31:0] imem_addr,
    input logic        redirect,
    input logic        ex_valid,
    input logic        wb_valid
);

    // address held for the whole four-phase cycle
    addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (imem_req || imem_ack) |=> $stable(imem_addr)
    ) else $error("imem_addr changed during a handshake");

    // a new request waits for ack to fall
    req_after_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(imem_req) |-> !imem_ack
    ) else $error("imem_req rose while imem_ack was high");

    reset_quiet: assert property (
        @(posedge clk)
        !rst_n |-> (!imem_req && !redirect && !ex_valid && !wb_valid)
    ) else $error("outputs active during reset");

endmodule

/* test/pipe_controller_tb.sv */
`timescale 1ns/10ps

module pipe_controller_tb;

    localparam logic [31:0] RESET_VEC = 32'h0000_0100;
    // 6 boot + 16x16 cond + 16 dp + 4 ls + 10 branch records
    localparam int LIMIT = 40 * 292;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic imem_ack = 1'b0;
    logic [31:0] imem_rdata = '0;
    logic [3:0] flags = '0;
    logic imem_req;
    logic ex_valid;
    logic ex_pass;
    logic use_imm;
    logic en_status;
    logic mem_r_en;
    logic mem_w_en;
    logic redirect;
    logic wb_valid;
    logic reg_w_en;
    logic ldr_w_en;
    logic [31:0] imem_addr;
    logic [31:0] redirect_pc;
    logic [3:0] alu_op;
    logic [3:0] rn;
    logic [3:0] rm;
    logic [3:0] reg_w_addr;
    logic [11:0] imm12;

    logic [31:0] prog [logic [31:0]];
    logic [31:0] ex_q[$];
    logic [31:0] pc_q[$];
    logic [31:0] wb_q[$];
    logic [3:0] run_flags = '0;
    int exp_n = 0;
    int ex_seen = 0;
    int wb_seen = 0;
    int delay = 0;
    int cycle_cnt = 0;
    logic checking = 1'b0;
    logic ex_valid_last = 1'b0;

    pipe_controller #(.RESET_VECTOR(RESET_VEC)) DUT (
        .clk(clk), .rst_n(rst_n), .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_ack(imem_ack), .imem_rdata(imem_rdata), .flags(flags),
        .ex_valid(ex_valid), .ex_pass(ex_pass), .alu_op(alu_op), .rn(rn), .rm(rm),
        .imm12(imm12), .use_imm(use_imm), .en_status(en_status), .mem_r_en(mem_r_en),
        .mem_w_en(mem_w_en), .redirect(redirect), .redirect_pc(redirect_pc),
        .wb_valid(wb_valid), .reg_w_en(reg_w_en), .ldr_w_en(ldr_w_en),
        .reg_w_addr(reg_w_addr)
    );

    bind pipe_controller pipe_controller_props u_props (
        .clk(clk), .rst_n(rst_n), .imem_req(imem_req), .imem_ack(imem_ack),
        .imem_addr(imem_addr), .redirect(redirect), .ex_valid(ex_valid),
        .wb_valid(wb_valid)
    );

    always #20 clk = ~clk;

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > LIMIT) begin
            $display("timeout: the tests ran past %0d cycles", LIMIT);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    // unwritten words are undefined-class no-ops built from the address
    function automatic logic [31:0] fetch_word(input logic [31:0] a);
        if (prog.exists(a)) begin
            return prog[a];
        end
        return {4'he, 2'b11, a[25:0] ^ a[31:6]};
    endfunction

    // conditions come in pairs and bit 0 inverts the pair
    function automatic logic cond_holds(input logic [3:0] c, input logic [3:0] f);
        logic r;
        case (c[3:1])
            3'd0: r = f[2];
            3'd1: r = f[1];
            3'd2: r = f[3];
            3'd3: r = f[0];
            3'd4: r = f[1] && !f[2];
            3'd5: r = (f[3] == f[0]);
            3'd6: r = !f[2] && (f[3] == f[0]);
            default: r = 1'b1;
        endcase
        if (c == 4'd15) begin
            return 1'b0;
        end
        if (c == 4'd14) begin
            return 1'b1;
        end
        return r ^ c[0];
    endfunction

    // instruction memory model with 0 to 3 cycles of ack delay
    always @(posedge clk) begin
        if (!rst_n) begin
            imem_ack <= 1'b0;
            delay <= 0;
        end else if (imem_ack) begin
            if (!imem_req) begin
                imem_ack <= 1'b0;
                delay <= $urandom % 4;
            end
        end else if (imem_req) begin
            if (delay == 0) begin
                imem_ack <= 1'b1;
                imem_rdata <= fetch_word(imem_addr);
            end else begin
                delay <= delay - 1;
            end
        end
    end

    task automatic check_ex();
        logic [31:0] w;
        logic [31:0] pc;
        logic [31:0] off;
        logic p;
        logic [1:0] cls;
        w = ex_q.pop_front();
        pc = pc_q.pop_front();
        p = cond_holds(w[31:28], run_flags);
        cls = w[27:26];
        off = {{8{w[23]}}, w[23:0]};
        check_eq("ex_pass", 32'(ex_pass), 32'(p));
        check_eq("alu_op", 32'(alu_op), 32'(w[24:21]));
        check_eq("rn", 32'(rn), 32'(w[19:16]));
        check_eq("rm", 32'(rm), 32'(w[3:0]));
        check_eq("imm12", 32'(imm12), 32'(w[11:0]));
        check_eq("use_imm", 32'(use_imm), 32'(w[25]));
        check_eq("en_status", 32'(en_status), 32'(p && cls == 2'd0 && w[20]));
        check_eq("mem_r_en", 32'(mem_r_en), 32'(p && cls == 2'd1 && w[20]));
        check_eq("mem_w_en", 32'(mem_w_en), 32'(p && cls == 2'd1 && !w[20]));
        check_eq("redirect", 32'(redirect), 32'(p && cls == 2'd2));
        if (p && cls == 2'd2) begin
            check_eq("redirect_pc", redirect_pc, pc + 32'd8 + off * 32'd4);
        end
        wb_q.push_back(w);
    endtask

    task automatic check_wb();
        logic [31:0] w;
        logic p;
        logic [1:0] cls;
        logic writes;
        logic ld;
        w = wb_q.pop_front();
        p = cond_holds(w[31:28], run_flags);
        cls = w[27:26];
        // opcodes 8 to 11 only compare
        writes = p && ((cls == 2'd0 && w[24:23] != 2'b10) || (cls == 2'd2 && w[24]));
        ld = p && cls == 2'd1 && w[20];
        check_eq("reg_w_en", 32'(reg_w_en), 32'(writes));
        check_eq("ldr_w_en", 32'(ldr_w_en), 32'(ld));
        if (writes || ld) begin
            check_eq("reg_w_addr", 32'(reg_w_addr), (cls == 2'd2) ? 32'd14 : 32'(w[15:12]));
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && checking) begin
            // write-back trails execute by one cycle
            check_eq("wb_valid", 32'(wb_valid), 32'(ex_valid_last));
            if (ex_valid) begin
                if (ex_seen < exp_n) begin
                    check_ex();
                    ex_seen = ex_seen + 1;
                end
            end else begin
                check_eq("redirect idle", 32'(redirect), 32'd0);
                check_eq("mem enables idle", 32'(mem_r_en || mem_w_en), 32'd0);
            end
            if (wb_valid && wb_seen < exp_n) begin
                check_wb();
                wb_seen = wb_seen + 1;
            end
        end
        ex_valid_last = ex_valid;
    end

    // reset the DUT and walk the program to list what execute should see
    task automatic start_run(input logic [3:0] f, input int n);
        logic [31:0] pc;
        logic [31:0] w;
        @(posedge clk);
        rst_n <= 1'b0;
        flags <= f;
        run_flags = f;
        ex_q.delete();
        pc_q.delete();
        wb_q.delete();
        pc = RESET_VEC;
        repeat (n) begin
            w = fetch_word(pc);
            ex_q.push_back(w);
            pc_q.push_back(pc);
            if (cond_holds(w[31:28], f) && w[27:26] == 2'd2) begin
                pc = pc + 32'd8 + {{8{w[23]}}, w[23:0]} * 32'd4;
            end else begin
                pc = pc + 32'd4;
            end
        end
        exp_n = n;
        ex_seen = 0;
        wb_seen = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        checking = 1'b1;
    endtask

    task automatic finish_run();
        while (wb_seen < exp_n) begin
            @(negedge clk);
        end
        checking = 1'b0;
    endtask

    function automatic logic [31:0] dp_word(input logic [3:0] c, input logic i,
                                            input logic [3:0] op, input logic s,
                                            input logic [3:0] rn_f, input logic [3:0] rd_f,
                                            input logic [11:0] low);
        return {c, 2'b00, i, op, s, rn_f, rd_f, low};
    endfunction

    task automatic boot_fetch();
        prog.delete();
        start_run(4'h0, 6);
        while (!imem_req) begin
            @(negedge clk);
        end
        check_eq("imem_addr", imem_addr, RESET_VEC);
        finish_run();
    endtask

    task automatic cond_exec();
        prog.delete();
        for (int c = 0; c < 16; c++) begin
            prog[RESET_VEC + 32'(c * 4)] = dp_word(4'(c), 1'b0, 4'd4, 1'b1, 4'(c),
                                                   4'(15 - c), 12'(c * 3 + 1));
        end
        for (int f = 0; f < 16; f++) begin
            start_run(4'(f), 16);
            finish_run();
        end
    endtask

    task automatic data_processing();
        prog.delete();
        for (int op = 0; op < 16; op++) begin
            prog[RESET_VEC + 32'(op * 4)] = dp_word(4'he, op[0], 4'(op), op[1], 4'(op),
                                                    4'(15 - op), {4'(op), 8'h5a});
        end
        start_run(4'h0, 16);
        finish_run();
    endtask

    task automatic load_store();
        prog.delete();
        prog[RESET_VEC]         = {4'he, 2'b01, 5'b0, 1'b1, 4'd1, 4'd2, 12'h010};
        prog[RESET_VEC + 32'd4] = {4'he, 2'b01, 5'b0, 1'b0, 4'd3, 4'd4, 12'h024};
        prog[RESET_VEC + 32'd8] = {4'he, 2'b01, 5'b0, 1'b1, 4'd5, 4'd6, 12'h038};
        prog[RESET_VEC + 32'd12] = {4'he, 2'b01, 5'b0, 1'b0, 4'd7, 4'd8, 12'h04c};
        start_run(4'h0, 4);
        finish_run();
    endtask

    // forward b, backward bl, two failing branches, then loop back
    task automatic branch_redirect();
        prog.delete();
        prog[32'h100] = {4'he, 2'b10, 1'b0, 1'b0, 24'd3};
        prog[32'h114] = {4'he, 2'b10, 1'b0, 1'b1, 24'hff_fff5};
        prog[32'h0f0] = {4'h1, 2'b10, 1'b0, 1'b0, 24'd5};
        prog[32'h0f4] = {4'h1, 2'b10, 1'b0, 1'b1, 24'hff_fff0};
        prog[32'h0f8] = dp_word(4'he, 1'b1, 4'd13, 1'b0, 4'd0, 4'd3, 12'h0c3);
        start_run(4'b0100, 10);
        finish_run();
    endtask

    initial begin
        void'($urandom(32'h5fe9_f967));
        boot_fetch();
        cond_exec();
        data_processing();
        load_store();
        branch_redirect();
        $display("RESULT: PASS");
        $finish;
    end

endmodule
